// ==== filelist.f ====
rtl/stream_pkg.sv
rtl/stream_csr.sv
rtl/burst_read_engine.sv
rtl/stream_fifo.sv
rtl/stream_from_memory.sv
testbench/tb_clock_gen.sv
testbench/avalon_memory_model.sv
testbench/tb_stream_from_memory.sv

// ==== Makefile ====
TOP = tb_stream_from_memory

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_16
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) \
		-Gdata_width=32 -Mdir obj_32

run: compile
	@out=$$(./obj_16/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Verification passed"
	@out=$$(./obj_32/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_16 obj_32

// ==== testbench/tb_stream_from_memory.sv ====
`timescale 1ns/1ns

module tb_stream_from_memory import stream_pkg::*; #(
    parameter int data_width = 16
);

    localparam int fifo_depth     = 64;
    localparam int bytes_per_word = data_width / 8;
    localparam int total_words    = 37 + 23 + 150;
    localparam int timeout_cycles = 200 + 20 * total_words;

    logic                          clock;
    logic                          clock_sreset;
    csr_addr_t                     s_address;
    csr_word_t                     s_writedata;
    csr_word_t                     s_readdata;
    logic                          s_read;
    logic                          s_write;
    logic                          s_waitrequest;
    addr_t                         m_address;
    burst_t                        m_burstcount;
    logic                          m_read;
    logic [data_width-1:0]         m_readdata;
    logic                          m_waitrequest;
    logic                          m_readdatavalid;
    logic                          fifo_rdreq;
    logic [data_width-1:0]         fifo_q;
    logic [$clog2(fifo_depth)-1:0] fifo_usedw;

    int                    error_count = 0;
    int                    test_count  = 0;
    int                    fail_count  = 0;
    int                    cur_burst   = 1;
    int                    fill_level  = 0;
    logic                  consume_en  = 1'b0;
    addr_t                 burst_addr[$];
    burst_t                burst_len[$];
    logic [data_width-1:0] popped[$];

    tb_clock_gen u_clock_gen (.clock(clock), .clock_sreset(clock_sreset));

    avalon_memory_model #(.data_width(data_width)) u_memory (
        .clock         (clock),
        .clock_sreset  (clock_sreset),
        .address       (m_address),
        .burstcount    (m_burstcount),
        .read          (m_read),
        .waitrequest   (m_waitrequest),
        .readdata      (m_readdata),
        .readdatavalid (m_readdatavalid)
    );

    stream_from_memory #(.data_width(data_width), .fifo_depth(fifo_depth)) u_stream_from_memory (
        .clock           (clock),
        .clock_sreset    (clock_sreset),
        .s_address       (s_address),
        .s_writedata     (s_writedata),
        .s_readdata      (s_readdata),
        .s_read          (s_read),
        .s_write         (s_write),
        .s_waitrequest   (s_waitrequest),
        .m_address       (m_address),
        .m_burstcount    (m_burstcount),
        .m_read          (m_read),
        .m_readdata      (m_readdata),
        .m_waitrequest   (m_waitrequest),
        .m_readdatavalid (m_readdatavalid),
        .fifo_rdreq      (fifo_rdreq),
        .fifo_q          (fifo_q),
        .fifo_usedw      (fifo_usedw)
    );

    task automatic report_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        error_count++;
    endtask

    function automatic logic [data_width-1:0] expected_word(logic [31:0] wa);
        logic [31:0] mix;
        mix = (wa * 32'h9e3779b1) ^ (wa >> 16);
        return mix[data_width-1:0];
    endfunction

    a_read_wait : assert property (@(posedge clock) disable iff (clock_sreset)
        $rose(s_read) |-> s_waitrequest ##1 !s_waitrequest)
        else report_error("register read wait is not exactly one cycle");

    a_request_stable : assert property (@(posedge clock) disable iff (clock_sreset)
        m_read && m_waitrequest |=> m_read && $stable(m_address) && $stable(m_burstcount))
        else report_error("burst request changed while waiting");

    a_usedw_bound : assert property (@(posedge clock) disable iff (clock_sreset)
        int'(fifo_usedw) == fill_level && fill_level <= fifo_depth - 1)
        else report_error($sformatf("fifo used count %0d, holding %0d words",
                                    fifo_usedw, fill_level));

    // a new request only with room for two bursts
    a_room_check : assert property (@(posedge clock) disable iff (clock_sreset)
        $rose(m_read) |-> int'($past(fifo_usedw)) < fifo_depth - 2 * cur_burst)
        else report_error("burst requested without fifo room");

    always @(posedge clock) begin
        if (!clock_sreset && m_read && !m_waitrequest) begin
            burst_addr.push_back(m_address);
            burst_len.push_back(m_burstcount);
        end
        if (!clock_sreset && fifo_rdreq) begin
            popped.push_back(fifo_q);
        end
    end

    // words returned but not yet popped
    always @(posedge clock) begin
        if (clock_sreset) begin
            fill_level <= 0;
        end else begin
            fill_level <= fill_level + int'(m_readdatavalid) - int'(fifo_rdreq);
        end
    end

    // consumer with random pauses
    always @(negedge clock) begin
        fifo_rdreq = consume_en && fifo_usedw != '0 && $urandom_range(3) != 0;
    end

    task automatic csr_write(input csr_addr_t addr, input csr_word_t data);
        s_write     = 1'b1;
        s_address   = addr;
        s_writedata = data;
        @(negedge clock);
        s_write     = 1'b0;
    endtask

    task automatic csr_read(input csr_addr_t addr, output csr_word_t data);
        int guard;
        guard     = 0;
        s_read    = 1'b1;
        s_address = addr;
        @(negedge clock);
        while (s_waitrequest && guard < 8) begin
            guard++;
            @(negedge clock);
        end
        data   = s_readdata;
        s_read = 1'b0;
        @(negedge clock);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: failed", name);
        end
    endtask

    task automatic run_transfer(input string name, input addr_t p, input int n,
                                input int b, input int pause);
        int        errors_before;
        int        n_bursts;
        int        expect_len;
        csr_word_t st;
        errors_before = error_count;
        burst_addr.delete();
        burst_len.delete();
        popped.delete();
        cur_burst  = b;
        consume_en = (pause == 0);
        csr_write(csr_pointer, p);
        csr_write(csr_size, csr_word_t'(n));
        csr_write(csr_command, (32'd1 << go_bit) | csr_word_t'(b));
        if (n == 0) repeat (3) @(negedge clock);
        else @(negedge clock);
        csr_read(csr_status, st);
        assert (st[0] == (n != 0))
            else report_error($sformatf("status busy %0d after go, size %0d", st[0], n));
        repeat (pause) @(negedge clock);
        consume_en = 1'b1;
        do csr_read(csr_status, st); while (st[0]);     // watchdog bounds this
        while (popped.size() < n) @(negedge clock);
        repeat (8) @(negedge clock);
        n_bursts = (n + b - 1) / b;
        assert (burst_len.size() == n_bursts)
            else report_error($sformatf("%0d bursts, expected %0d", burst_len.size(), n_bursts));
        for (int k = 0; k < burst_len.size() && k < n_bursts; k++) begin
            expect_len = (n - k * b < b) ? n - k * b : b;
            assert (int'(burst_len[k]) == expect_len)
                else report_error($sformatf("burst %0d length %0d, expected %0d",
                                            k, burst_len[k], expect_len));
            assert (burst_addr[k] == p + addr_t'(k * b * bytes_per_word))
                else report_error($sformatf("burst %0d address %h", k, burst_addr[k]));
        end
        assert (popped.size() == n)
            else report_error($sformatf("%0d words popped, expected %0d", popped.size(), n));
        for (int i = 0; i < popped.size() && i < n; i++) begin
            assert (popped[i] == expected_word(p / bytes_per_word + i))
                else report_error($sformatf("word %0d is %h, expected %h", i, popped[i],
                                            expected_word(p / bytes_per_word + i)));
        end
        finish_test(name, errors_before);
    endtask

    initial begin
        timer_start: begin
            #(timeout_cycles * 10);
            $display("run stopped by watchdog after %0d cycles", timeout_cycles);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        csr_word_t st;
        int        errors_before;
        s_address   = '0;
        s_writedata = '0;
        s_read      = 1'b0;
        s_write     = 1'b0;
        fifo_rdreq  = 1'b0;
        void'($urandom(40626));
        @(negedge clock);
        while (clock_sreset) @(negedge clock);

        errors_before = error_count;
        assert (m_read == 1'b0) else report_error("m_read high after reset");
        assert (fifo_usedw == '0) else report_error("fifo not empty after reset");
        csr_read(csr_status, st);
        assert (st == '0) else report_error($sformatf("status %h after reset", st));
        finish_test("reset_state", errors_before);

        errors_before = error_count;
        csr_write(csr_command, 32'h0000_01a5);      // go bit clear
        csr_write(csr_pointer, 32'h1234_5678);
        csr_write(csr_size, 32'hab12_3456);
        csr_read(csr_command, st);
        assert (st == 32'h0000_00a5) else report_error($sformatf("burst reads %h", st));
        csr_read(csr_pointer, st);
        assert (st == 32'h1234_5678) else report_error($sformatf("pointer reads %h", st));
        csr_read(csr_size, st);
        assert (st == 32'h0012_3456) else report_error($sformatf("size reads %h", st));
        finish_test("register_readback", errors_before);

        run_transfer("zero_size", 32'h0000_0400, 0, 8, 0);
        run_transfer("burst_plan", 32'h0000_1000, 37, 8, 0);
        run_transfer("odd_burst", 32'h0000_3000, 23, 5, 0);
        run_transfer("back_pressure", 32'h0000_2000, 150, 8, 300);

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 test_count, test_count - fail_count, fail_count, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== testbench/avalon_memory_model.sv ====
`timescale 1ns/1ns

module avalon_memory_model #(
    parameter int data_width = 16
) (
    input  logic                  clock,
    input  logic                  clock_sreset,

    input  logic [31:0]           address,
    input  logic [7:0]            burstcount,
    input  logic                  read,
    output logic                  waitrequest,
    output logic [data_width-1:0] readdata,
    output logic                  readdatavalid
);

    localparam int bytes_per_word = data_width / 8;

    logic [31:0] word_addr;     // next word to return
    int          remaining;     // words left in the current burst

    // high address bits fold into the low ones
    function automatic logic [data_width-1:0] fill_word(logic [31:0] wa);
        logic [31:0] mix;
        mix = (wa * 32'h9e3779b1) ^ (wa >> 16);
        return mix[data_width-1:0];
    endfunction

    initial begin
        waitrequest   = 1'b1;
        readdata      = '0;
        readdatavalid = 1'b0;
        word_addr     = '0;
        remaining     = 0;
    end

    // outputs change on the falling edge only
    always @(negedge clock) begin
        if (clock_sreset) begin
            waitrequest   = 1'b1;
            readdatavalid = 1'b0;
            remaining     = 0;
        end else begin
            readdatavalid = 1'b0;
            if (remaining != 0 && $urandom_range(3) != 0) begin   // gaps in the return
                readdata      = fill_word(word_addr);
                readdatavalid = 1'b1;
                word_addr     = word_addr + 32'd1;
                remaining     = remaining - 1;
            end
            // one burst at a time, random wait states before acceptance
            if (remaining == 0 && read && $urandom_range(2) != 0) begin
                waitrequest = 1'b0;
                word_addr   = address / bytes_per_word;
                remaining   = int'(burstcount);
            end else begin
                waitrequest = 1'b1;
            end
        end
    end

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clock,
    output logic clock_sreset
);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;      // 10 ns period
    end

    initial begin
        clock_sreset = 1'b1;
        repeat (2) @(posedge clock);
        clock_sreset <= 1'b0;
    end

endmodule

// ==== rtl/stream_from_memory.sv ====
`timescale 1ns/1ns

module stream_from_memory import stream_pkg::*; #(
    parameter int data_width = 16,
    parameter int fifo_depth = 512
) (
    input  logic                          clock,
    input  logic                          clock_sreset,

    input  csr_addr_t                     s_address,
    input  csr_word_t                     s_writedata,
    output csr_word_t                     s_readdata,
    input  logic                          s_read,
    input  logic                          s_write,
    output logic                          s_waitrequest,

    output addr_t                         m_address,
    output burst_t                        m_burstcount,
    output logic                          m_read,
    input  logic [data_width-1:0]         m_readdata,
    input  logic                          m_waitrequest,
    input  logic                          m_readdatavalid,

    input  logic                          fifo_rdreq,
    output logic [data_width-1:0]         fifo_q,
    output logic [$clog2(fifo_depth)-1:0] fifo_usedw
);

    stream_cmd_t cmd;
    logic        go;
    logic        busy;

    stream_csr u_csr (
        .clock         (clock),
        .clock_sreset  (clock_sreset),
        .s_address     (s_address),
        .s_writedata   (s_writedata),
        .s_readdata    (s_readdata),
        .s_read        (s_read),
        .s_write       (s_write),
        .s_waitrequest (s_waitrequest),
        .go            (go),
        .cmd           (cmd),
        .busy          (busy)
    );

    burst_read_engine #(
        .data_width (data_width),
        .fifo_depth (fifo_depth)
    ) u_engine (
        .clock         (clock),
        .clock_sreset  (clock_sreset),
        .cmd           (cmd),
        .go            (go),
        .fifo_usedw    (fifo_usedw),
        .busy          (busy),
        .m_address     (m_address),
        .m_burstcount  (m_burstcount),
        .m_read        (m_read),
        .m_waitrequest (m_waitrequest)
    );

    // read data lands straight in the buffer
    stream_fifo #(
        .data_width (data_width),
        .fifo_depth (fifo_depth)
    ) u_fifo (
        .clock        (clock),
        .clock_sreset (clock_sreset),
        .wr_data      (m_readdata),
        .wr_en        (m_readdatavalid),
        .rd_en        (fifo_rdreq),
        .rd_data      (fifo_q),
        .used_words   (fifo_usedw)
    );

endmodule

// ==== rtl/stream_fifo.sv ====
`timescale 1ns/1ns

module stream_fifo #(
    parameter int data_width = 16,
    parameter int fifo_depth = 512
) (
    input  logic                          clock,
    input  logic                          clock_sreset,

    input  logic [data_width-1:0]         wr_data,
    input  logic                          wr_en,
    input  logic                          rd_en,
    output logic [data_width-1:0]         rd_data,
    output logic [$clog2(fifo_depth)-1:0] used_words
);

    localparam int count_width = $clog2(fifo_depth);

    logic [data_width-1:0]  mem [fifo_depth];
    logic [count_width-1:0] wr_ptr;
    logic [count_width-1:0] rd_ptr;
    logic                   full;
    logic                   empty;

    always_comb begin
        full    = &used_words;          // one slot always stays free
        empty   = used_words == '0;
        rd_data = mem[rd_ptr];          // show-ahead
    end

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            used_words <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   used_words <= used_words + 1'b1;
                2'b01:   used_words <= used_words - 1'b1;
                default: ;                  // both or neither
            endcase
        end
    end

    a_no_overflow : assert property (@(posedge clock) disable iff (clock_sreset)
        full |-> !wr_en || rd_en);

    a_no_underflow : assert property (@(posedge clock) disable iff (clock_sreset)
        rd_en |-> !empty);

endmodule

// ==== rtl/burst_read_engine.sv ====
`timescale 1ns/1ns

module burst_read_engine import stream_pkg::*; #(
    parameter int data_width = 16,
    parameter int fifo_depth = 512
) (
    input  logic                          clock,
    input  logic                          clock_sreset,

    input  stream_cmd_t                   cmd,
    input  logic                          go,
    input  logic [$clog2(fifo_depth)-1:0] fifo_usedw,
    output logic                          busy,

    output addr_t                         m_address,
    output burst_t                        m_burstcount,
    output logic                          m_read,
    input  logic                          m_waitrequest
);

    localparam int bytes_per_word = data_width / 8;

    engine_state_t state;
    count_t        word_counter;    // words not yet requested
    logic          last_burst;
    logic          has_room;

    always_comb begin
        last_burst = word_counter <= count_t'(cmd.burst_count);
        // keep space for two bursts in flight
        has_room   = int'(fifo_usedw) < fifo_depth - 2 * int'(cmd.burst_count);
    end

    // control state
    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            state  <= engine_idle;
            busy   <= 1'b0;
            m_read <= 1'b0;
        end else begin
            case (state)
                engine_idle: begin
                    if (go) begin
                        busy  <= 1'b1;
                        state <= engine_burst;
                    end
                end
                engine_burst: begin
                    if (m_read) begin
                        if (!m_waitrequest) begin               // burst accepted
                            m_read <= 1'b0;
                            if (word_counter == '0) begin
                                busy  <= 1'b0;
                                state <= engine_idle;
                            end
                        end
                    end else if (word_counter == '0) begin      // empty transfer
                        busy  <= 1'b0;
                        state <= engine_idle;
                    end else if (has_room) begin
                        m_read <= 1'b1;
                    end
                end
                default: state <= engine_idle;
            endcase
        end
    end

    // address, burst size and word bookkeeping
    always_ff @(posedge clock) begin
        case (state)
            engine_idle: begin
                m_address    <= cmd.source_pointer;
                word_counter <= cmd.word_size;
            end
            engine_burst: begin
                if (m_read) begin
                    if (!m_waitrequest) begin
                        m_address <= m_address
                                   + addr_t'(m_burstcount) * addr_t'(bytes_per_word);
                    end
                end else if (word_counter != '0 && has_room) begin
                    if (last_burst) begin                       // short tail burst
                        m_burstcount <= burst_t'(word_counter);
                        word_counter <= '0;
                    end else begin
                        m_burstcount <= cmd.burst_count;
                        word_counter <= word_counter - count_t'(cmd.burst_count);
                    end
                end
            end
            default: ;
        endcase
    end

    a_request_held : assert property (@(posedge clock) disable iff (clock_sreset)
        m_read && m_waitrequest |=> m_read && $stable(m_address) && $stable(m_burstcount));

    a_burst_nonzero : assert property (@(posedge clock) disable iff (clock_sreset)
        m_read |-> m_burstcount != '0);

endmodule

// ==== rtl/stream_csr.sv ====
`timescale 1ns/1ns

module stream_csr import stream_pkg::*; (
    input  logic        clock,
    input  logic        clock_sreset,

    input  csr_addr_t   s_address,
    input  csr_word_t   s_writedata,
    output csr_word_t   s_readdata,
    input  logic        s_read,
    input  logic        s_write,
    output logic        s_waitrequest,

    output logic        go,
    output stream_cmd_t cmd,
    input  logic        busy
);

    logic read_latency;     // second cycle of a read

    // reads wait one cycle, writes never wait
    always_comb begin
        s_waitrequest = s_read && !s_write && !read_latency;
    end

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            read_latency <= 1'b0;
            go           <= 1'b0;
        end else begin
            read_latency <= read_latency ? 1'b0 : s_read;
            go           <= s_write && (s_address == csr_command) && s_writedata[go_bit];
        end
    end

    // register file, no reset on the descriptor
    always_ff @(posedge clock) begin
        if (s_write) begin
            case (s_address)
                csr_command: cmd.burst_count    <= s_writedata[7:0];
                csr_pointer: cmd.source_pointer <= s_writedata;
                csr_size:    cmd.word_size      <= s_writedata[23:0];
                default: ;                          // status is read only
            endcase
        end
    end

    // readback is registered, valid once the wait drops
    always_ff @(posedge clock) begin
        if (s_read) begin
            case (s_address)
                csr_command: s_readdata <= {24'b0, cmd.burst_count};
                csr_status:  s_readdata <= {31'b0, busy};
                csr_pointer: s_readdata <= cmd.source_pointer;
                default:     s_readdata <= {8'b0, cmd.word_size};
            endcase
        end
    end

    // a go is a single strobe per command write
    a_go_pulse : assert property (@(posedge clock) disable iff (clock_sreset)
        go |=> !go);

endmodule

// ==== rtl/stream_pkg.sv ====
package stream_pkg;

    // widths with a meaning of their own
    typedef logic [31:0] addr_t;        // byte address
    typedef logic [23:0] count_t;       // words in a transfer
    typedef logic [7:0]  burst_t;       // words per burst
    typedef logic [1:0]  csr_addr_t;
    typedef logic [31:0] csr_word_t;

    // transfer descriptor handed from the register file to the engine
    typedef struct packed {
        addr_t  source_pointer;
        count_t word_size;
        burst_t burst_count;
    } stream_cmd_t;

    typedef enum logic [0:0] {
        engine_idle,
        engine_burst
    } engine_state_t;

    // register map
    localparam csr_addr_t csr_command = 2'd0;   // burst length, go
    localparam csr_addr_t csr_status  = 2'd1;   // busy in bit 0
    localparam csr_addr_t csr_pointer = 2'd2;
    localparam csr_addr_t csr_size    = 2'd3;

    localparam int go_bit = 15;

endpackage
